// ==== hdl/uop_pkg.sv ====
package uop_pkg;

    localparam int XLEN      = 32;
    localparam int REG_IDX_W = 5;
    localparam int TAG_W     = 4;
    localparam int MEM_OP_W  = 4;

    // register values, addresses and results
    typedef logic [XLEN-1:0]      word_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;
    typedef logic [TAG_W-1:0]     tag_t;    // commit order

    // memory operation carried by the micro-op
    typedef enum logic [MEM_OP_W-1:0] {
        MEM_NONE = 4'd0,
        MEM_LB   = 4'd1,
        MEM_LH   = 4'd2,
        MEM_LW   = 4'd3,
        MEM_LBU  = 4'd4,
        MEM_LHU  = 4'd5,
        MEM_SB   = 4'd6,
        MEM_SH   = 4'd7,
        MEM_SW   = 4'd8
    } mem_op_t;

    // four-phase handshake toward L1
    typedef enum logic [1:0] {
        BUS_IDLE    = 2'd0,
        BUS_REQ     = 2'd1,   // req high until ack
        BUS_RELEASE = 2'd2,   // req low until ack low
        BUS_DONE    = 2'd3
    } bus_state_t;

endpackage

// ==== hdl/bus_pkg.sv ====
package bus_pkg;

    localparam int L1_ADDR_W = 32;
    localparam int L1_DATA_W = 32;
    localparam int L1_MASK_W = L1_DATA_W / 8;   // one bit per byte lane

    typedef logic [L1_ADDR_W-1:0] l1_addr_t;
    typedef logic [L1_DATA_W-1:0] l1_data_t;
    typedef logic [L1_MASK_W-1:0] byte_mask_t;

endpackage

// ==== hdl/mem_op_decode.sv ====
`timescale 1ns/1ns

module mem_op_decode
    import uop_pkg::*;
    import bus_pkg::*;
(
    input  logic       clk_i,
    input  logic       rstn_i,
    input  logic       uop_valid_i,
    input  mem_op_t    uop_op_i,
    input  word_t      uop_a_i,
    input  word_t      uop_b_i,
    input  word_t      uop_imm_i,
    input  reg_idx_t   uop_rd_i,
    input  tag_t       uop_tag_i,
    input  logic       take_i,
    output logic       s1_valid_o,
    output mem_op_t    s1_op_o,
    output word_t      s1_addr_o,
    output l1_data_t   s1_wdata_o,
    output byte_mask_t s1_mask_o,
    output reg_idx_t   s1_rd_o,
    output tag_t       s1_tag_o,
    output logic       stall_o
);

    logic       load;
    word_t      addr;
    byte_mask_t mask;
    l1_data_t   wdata;

    assign load    = !s1_valid_o || take_i;   // empty, or draining this cycle
    assign stall_o = s1_valid_o && !take_i;

    always_comb begin
        // non-memory ops carry their result in the address field
        addr = (uop_op_i == MEM_NONE) ? uop_a_i : uop_a_i + uop_imm_i;

        case (uop_op_i)
            MEM_LB, MEM_LBU, MEM_SB: mask = byte_mask_t'(4'b0001 << addr[1:0]);
            MEM_LH, MEM_LHU, MEM_SH: mask = addr[1] ? 4'b1100 : 4'b0011;
            MEM_LW, MEM_SW:          mask = 4'b1111;
            default:                 mask = '0;
        endcase

        // move store data into its byte lanes
        case (uop_op_i)
            MEM_SB:  wdata = l1_data_t'(uop_b_i[7:0]) << {addr[1:0], 3'b000};
            MEM_SH:  wdata = l1_data_t'(uop_b_i[15:0]) << {addr[1], 4'b0000};
            MEM_SW:  wdata = uop_b_i;
            default: wdata = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            s1_valid_o <= 1'b0;
        end else if (load) begin
            s1_valid_o <= uop_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (load && uop_valid_i) begin
            s1_op_o    <= uop_op_i;
            s1_addr_o  <= addr;
            s1_wdata_o <= wdata;
            s1_mask_o  <= mask;
            s1_rd_o    <= uop_rd_i;
            s1_tag_o   <= uop_tag_i;
        end
    end

endmodule

// ==== hdl/data_bus_unit.sv ====
`timescale 1ns/1ns

module data_bus_unit
    import uop_pkg::*;
    import bus_pkg::*;
(
    input  logic       clk_i,
    input  logic       rstn_i,
    input  logic       s1_valid_i,
    input  mem_op_t    s1_op_i,
    input  word_t      s1_addr_i,
    input  l1_data_t   s1_wdata_i,
    input  byte_mask_t s1_mask_i,
    input  reg_idx_t   s1_rd_i,
    input  tag_t       s1_tag_i,
    output logic       take_o,
    output logic       l1_req_o,
    output logic       l1_we_o,
    output l1_addr_t   l1_addr_o,
    output l1_data_t   l1_wdata_o,
    output byte_mask_t l1_wmask_o,
    input  logic       l1_ack_i,
    input  l1_data_t   l1_rdata_i,
    output logic       s2_valid_o,
    output mem_op_t    s2_op_o,
    output word_t      s2_data_o,
    output logic [1:0] s2_byte_sel_o,
    output reg_idx_t   s2_rd_o,
    output tag_t       s2_tag_o
);

    bus_state_t state_q;
    bus_state_t state_d;

    mem_op_t    op_q;
    word_t      addr_q;
    l1_data_t   wdata_q;
    byte_mask_t mask_q;
    reg_idx_t   rd_q;
    tag_t       tag_q;
    word_t      data_q;     // result for non-memory ops, read data for loads

    logic       take_item;
    logic       is_store;

    assign take_o    = (state_q == BUS_IDLE) || (state_q == BUS_DONE);
    assign take_item = take_o && s1_valid_i;
    assign is_store  = op_q inside {MEM_SB, MEM_SH, MEM_SW};

    always_comb begin
        state_d = state_q;
        case (state_q)
            BUS_IDLE, BUS_DONE: begin
                if (s1_valid_i) begin
                    state_d = (s1_op_i == MEM_NONE) ? BUS_DONE : BUS_REQ;
                end else begin
                    state_d = BUS_IDLE;
                end
            end
            BUS_REQ: begin
                if (l1_ack_i) begin
                    state_d = BUS_RELEASE;
                end
            end
            BUS_RELEASE: begin
                // ack must be seen low before the next req
                if (!l1_ack_i) begin
                    state_d = BUS_DONE;
                end
            end
            default: state_d = BUS_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_q <= BUS_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (take_item) begin
            op_q    <= s1_op_i;
            addr_q  <= s1_addr_i;
            wdata_q <= s1_wdata_i;
            mask_q  <= s1_mask_i;
            rd_q    <= s1_rd_i;
            tag_q   <= s1_tag_i;
            data_q  <= s1_addr_i;
        end else if (state_q == BUS_REQ && l1_ack_i && !is_store) begin
            data_q <= l1_rdata_i;   // rdata valid while ack high
        end
    end

    // item registers hold the bus side stable while req is high
    assign l1_req_o   = (state_q == BUS_REQ);
    assign l1_we_o    = is_store;
    assign l1_addr_o  = {addr_q[L1_ADDR_W-1:2], 2'b00};
    assign l1_wdata_o = wdata_q;
    assign l1_wmask_o = mask_q;

    assign s2_valid_o    = (state_q == BUS_DONE);
    assign s2_op_o       = op_q;
    assign s2_data_o     = data_q;
    assign s2_byte_sel_o = addr_q[1:0];
    assign s2_rd_o       = rd_q;
    assign s2_tag_o      = tag_q;

endmodule

// ==== hdl/load_align.sv ====
`timescale 1ns/1ns

module load_align
    import uop_pkg::*;
(
    input  logic       clk_i,
    input  logic       rstn_i,
    input  logic       s2_valid_i,
    input  mem_op_t    s2_op_i,
    input  word_t      s2_data_i,
    input  logic [1:0] s2_byte_sel_i,
    input  reg_idx_t   s2_rd_i,
    input  tag_t       s2_tag_i,
    output logic       wb_valid_o,
    output logic       wb_we_o,
    output reg_idx_t   wb_rd_o,
    output word_t      wb_data_o,
    output tag_t       wb_tag_o
);

    word_t       shifted;
    logic [7:0]  lane_b;
    logic [15:0] lane_h;
    word_t       ext;
    logic        we;

    always_comb begin
        shifted = s2_data_i >> {s2_byte_sel_i, 3'b000};
        lane_b  = shifted[7:0];
        lane_h  = s2_byte_sel_i[1] ? s2_data_i[31:16] : s2_data_i[15:0];

        case (s2_op_i)
            MEM_LB:           ext = {{24{lane_b[7]}}, lane_b};
            MEM_LBU:          ext = {24'b0, lane_b};
            MEM_LH:           ext = {{16{lane_h[15]}}, lane_h};
            MEM_LHU:          ext = {16'b0, lane_h};
            MEM_LW, MEM_NONE: ext = s2_data_i;
            default:          ext = '0;     // stores write back nothing
        endcase

        // x0 is never written
        we = !(s2_op_i inside {MEM_SB, MEM_SH, MEM_SW}) && (s2_rd_i != '0);
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            wb_valid_o <= 1'b0;
        end else begin
            wb_valid_o <= s2_valid_i;   // one-cycle pulse per item
        end
    end

    always_ff @(posedge clk_i) begin
        if (s2_valid_i) begin
            wb_we_o   <= we;
            wb_rd_o   <= s2_rd_i;
            wb_data_o <= ext;
            wb_tag_o  <= s2_tag_i;
        end
    end

endmodule

// ==== hdl/mem_stage.sv ====
`timescale 1ns/1ns

module mem_stage
    import uop_pkg::*;
    import bus_pkg::*;
(
    input  logic       clk_i,
    input  logic       rstn_i,
    input  logic       uop_valid_i,
    input  mem_op_t    uop_op_i,
    input  word_t      uop_a_i,
    input  word_t      uop_b_i,
    input  word_t      uop_imm_i,
    input  reg_idx_t   uop_rd_i,
    input  tag_t       uop_tag_i,
    output logic       stall_o,
    output logic       l1_req_o,
    output logic       l1_we_o,
    output l1_addr_t   l1_addr_o,
    output l1_data_t   l1_wdata_o,
    output byte_mask_t l1_wmask_o,
    input  logic       l1_ack_i,
    input  l1_data_t   l1_rdata_i,
    output logic       wb_valid_o,
    output logic       wb_we_o,
    output reg_idx_t   wb_rd_o,
    output word_t      wb_data_o,
    output tag_t       wb_tag_o
);

    // decode -> bus unit
    logic       s1_valid;
    mem_op_t    s1_op;
    word_t      s1_addr;
    l1_data_t   s1_wdata;
    byte_mask_t s1_mask;
    reg_idx_t   s1_rd;
    tag_t       s1_tag;
    logic       take;

    // bus unit -> align
    logic       s2_valid;
    mem_op_t    s2_op;
    word_t      s2_data;
    logic [1:0] s2_byte_sel;
    reg_idx_t   s2_rd;
    tag_t       s2_tag;

    mem_op_decode i_mem_op_decode (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .uop_valid_i (uop_valid_i),
        .uop_op_i    (uop_op_i),
        .uop_a_i     (uop_a_i),
        .uop_b_i     (uop_b_i),
        .uop_imm_i   (uop_imm_i),
        .uop_rd_i    (uop_rd_i),
        .uop_tag_i   (uop_tag_i),
        .take_i      (take),
        .s1_valid_o  (s1_valid),
        .s1_op_o     (s1_op),
        .s1_addr_o   (s1_addr),
        .s1_wdata_o  (s1_wdata),
        .s1_mask_o   (s1_mask),
        .s1_rd_o     (s1_rd),
        .s1_tag_o    (s1_tag),
        .stall_o     (stall_o)
    );

    data_bus_unit i_data_bus_unit (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .s1_valid_i    (s1_valid),
        .s1_op_i       (s1_op),
        .s1_addr_i     (s1_addr),
        .s1_wdata_i    (s1_wdata),
        .s1_mask_i     (s1_mask),
        .s1_rd_i       (s1_rd),
        .s1_tag_i      (s1_tag),
        .take_o        (take),
        .l1_req_o      (l1_req_o),
        .l1_we_o       (l1_we_o),
        .l1_addr_o     (l1_addr_o),
        .l1_wdata_o    (l1_wdata_o),
        .l1_wmask_o    (l1_wmask_o),
        .l1_ack_i      (l1_ack_i),
        .l1_rdata_i    (l1_rdata_i),
        .s2_valid_o    (s2_valid),
        .s2_op_o       (s2_op),
        .s2_data_o     (s2_data),
        .s2_byte_sel_o (s2_byte_sel),
        .s2_rd_o       (s2_rd),
        .s2_tag_o      (s2_tag)
    );

    load_align i_load_align (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .s2_valid_i    (s2_valid),
        .s2_op_i       (s2_op),
        .s2_data_i     (s2_data),
        .s2_byte_sel_i (s2_byte_sel),
        .s2_rd_i       (s2_rd),
        .s2_tag_i      (s2_tag),
        .wb_valid_o    (wb_valid_o),
        .wb_we_o       (wb_we_o),
        .wb_rd_o       (wb_rd_o),
        .wb_data_o     (wb_data_o),
        .wb_tag_o      (wb_tag_o)
    );

endmodule

// ==== verif/mem_checker.sv ====
`timescale 1ns/1ns

module mem_checker
    import uop_pkg::*;
    import bus_pkg::*;
#(
    parameter int N_OPS = 24
) (
    input  logic       clk_i,
    input  logic       rstn_i,
    input  logic       wb_valid_i,
    input  logic       wb_we_i,
    input  reg_idx_t   wb_rd_i,
    input  word_t      wb_data_i,
    input  tag_t       wb_tag_i,
    input  logic       l1_req_i,
    input  logic       l1_we_i,
    input  l1_addr_t   l1_addr_i,
    input  l1_data_t   l1_wdata_i,
    input  byte_mask_t l1_wmask_i,
    input  logic       l1_ack_i,
    output int         wb_count_o,
    output int         data_errors_o,
    output int         proto_errors_o
);

    logic [31:0] golden [0:N_OPS*8-1];
    int          wb_count = 0;
    int          data_errors = 0;
    int          proto_errors = 0;
    logic        prev_req = 1'b0;
    logic        prev_ack = 1'b0;
    logic        prev_we;
    l1_addr_t    prev_addr;
    l1_data_t    prev_wdata;
    byte_mask_t  prev_mask;

    assign wb_count_o     = wb_count;
    assign data_errors_o  = data_errors;
    assign proto_errors_o = proto_errors;

    initial $readmemh("verif/mem_golden.txt", golden);

    function automatic int compare_field(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %0t %s: got %h expected %h", $time, name, got, exp);
            return 1;
        end
        return 0;
    endfunction

    // write-back fields in golden order
    always @(negedge clk_i) begin
        int n;
        int base;
        n = 0;
        base = wb_count * 8;
        if (rstn_i === 1'b1 && wb_valid_i === 1'b1) begin
            if (wb_count >= N_OPS) begin
                $display("extra write-back with tag %h after the last micro-op", wb_tag_i);
                n = 1;
            end else begin
                n = n + compare_field("wb_tag_o", 32'(wb_tag_i), golden[base+5]);
                n = n + compare_field("wb_rd_o", 32'(wb_rd_i), golden[base+4]);
                n = n + compare_field("wb_we_o", 32'(wb_we_i), golden[base+6]);
                n = n + compare_field("wb_data_o", wb_data_i, golden[base+7]);
            end
            wb_count    <= wb_count + 1;
            data_errors <= data_errors + n;
        end
    end

    // four-phase req/ack rules
    always @(negedge clk_i) begin
        int m;
        m = 0;
        if (rstn_i === 1'b1) begin
            if (l1_req_i && !prev_req && l1_ack_i) begin
                $display("req raised while ack still high at %0t", $time);
                m++;
            end
            if (l1_req_i && prev_req && ({l1_we_i, l1_addr_i, l1_wdata_i, l1_wmask_i}
                    !== {prev_we, prev_addr, prev_wdata, prev_mask})) begin
                $display("request fields changed while req was high at %0t", $time);
                m++;
            end
            if (!l1_req_i && prev_req && !prev_ack) begin
                $display("req dropped before ack at %0t", $time);
                m++;
            end
        end
        prev_req     <= (rstn_i === 1'b1) && (l1_req_i === 1'b1);
        prev_ack     <= l1_ack_i;
        prev_we      <= l1_we_i;
        prev_addr    <= l1_addr_i;
        prev_wdata   <= l1_wdata_i;
        prev_mask    <= l1_wmask_i;
        proto_errors <= proto_errors + m;
    end

endmodule

// ==== verif/tb_mem_stage.sv ====
`timescale 1ns/1ns

module tb_mem_stage
    import uop_pkg::*;
    import bus_pkg::*;
();

    localparam int N_OPS      = 24;
    localparam int STALL_WAIT = 64;    // cycles one micro-op may wait for the stage
    localparam int DRAIN_WAIT = 400;
    localparam int ACK_WAIT   = 32;

    logic       clk_i = 1'b0;
    logic       rstn_i;
    logic       uop_valid;
    mem_op_t    uop_op;
    word_t      uop_a;
    word_t      uop_b;
    word_t      uop_imm;
    reg_idx_t   uop_rd;
    tag_t       uop_tag;
    logic       stall;
    logic       l1_req;
    logic       l1_we;
    l1_addr_t   l1_addr;
    l1_data_t   l1_wdata;
    byte_mask_t l1_wmask;
    logic       l1_ack;
    l1_data_t   l1_rdata;
    logic       wb_valid;
    logic       wb_we;
    reg_idx_t   wb_rd;
    word_t      wb_data;
    tag_t       wb_tag;

    logic [31:0] golden [0:N_OPS*8-1];   // 8 columns per micro-op
    l1_data_t    l1_mem [0:63];
    integer      seed = 32'h9a04;
    int          tb_errors = 0;
    int          resp_errors = 0;
    int          wb_count;
    int          data_errors;
    int          proto_errors;

    always #2 clk_i = ~clk_i;

    mem_stage i_mem_stage (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .uop_valid_i (uop_valid),
        .uop_op_i    (uop_op),
        .uop_a_i     (uop_a),
        .uop_b_i     (uop_b),
        .uop_imm_i   (uop_imm),
        .uop_rd_i    (uop_rd),
        .uop_tag_i   (uop_tag),
        .stall_o     (stall),
        .l1_req_o    (l1_req),
        .l1_we_o     (l1_we),
        .l1_addr_o   (l1_addr),
        .l1_wdata_o  (l1_wdata),
        .l1_wmask_o  (l1_wmask),
        .l1_ack_i    (l1_ack),
        .l1_rdata_i  (l1_rdata),
        .wb_valid_o  (wb_valid),
        .wb_we_o     (wb_we),
        .wb_rd_o     (wb_rd),
        .wb_data_o   (wb_data),
        .wb_tag_o    (wb_tag)
    );

    mem_checker #(.N_OPS(N_OPS)) i_mem_checker (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .wb_valid_i     (wb_valid),
        .wb_we_i        (wb_we),
        .wb_rd_i        (wb_rd),
        .wb_data_i      (wb_data),
        .wb_tag_i       (wb_tag),
        .l1_req_i       (l1_req),
        .l1_we_i        (l1_we),
        .l1_addr_i      (l1_addr),
        .l1_wdata_i     (l1_wdata),
        .l1_wmask_i     (l1_wmask),
        .l1_ack_i       (l1_ack),
        .wb_count_o     (wb_count),
        .data_errors_o  (data_errors),
        .proto_errors_o (proto_errors)
    );

    // present one golden line and hold it until the stage takes it
    task automatic issue_uop(input int idx, output bit ok);
        int waited;
        int base;
        base = idx * 8;
        uop_valid <= 1'b1;
        uop_op    <= mem_op_t'(golden[base][3:0]);
        uop_a     <= golden[base+1];
        uop_b     <= golden[base+2];
        uop_imm   <= golden[base+3];
        uop_rd    <= golden[base+4][4:0];
        uop_tag   <= golden[base+5][3:0];
        ok = 1'b0;
        waited = 0;
        while (!ok && waited < STALL_WAIT) begin
            @(negedge clk_i);
            ok = !stall;    // taken on the coming edge
            @(posedge clk_i);
            waited++;
        end
    endtask

    // L1 model with random ack delay
    initial begin : l1_responder
        int         delay;
        int         waited;
        bit         dropped;
        logic [5:0] idx;
        logic       we;
        l1_data_t   wdata;
        byte_mask_t wmask;
        l1_ack   <= 1'b0;
        l1_rdata <= '0;
        for (int k = 0; k < 64; k++) begin
            l1_mem[k] = k * 32'h01010101 ^ 32'h80402010;
        end
        forever begin
            @(negedge clk_i);
            if (rstn_i === 1'b1 && l1_req === 1'b1 && l1_ack == 1'b0) begin
                idx   = l1_addr[7:2];
                we    = l1_we;
                wdata = l1_wdata;
                wmask = l1_wmask;
                delay = $unsigned($random(seed)) % 4;
                repeat (delay) @(posedge clk_i);
                @(posedge clk_i);
                if (we) begin
                    for (int b = 0; b < 4; b++) begin
                        if (wmask[b]) l1_mem[idx][8*b +: 8] = wdata[8*b +: 8];
                    end
                end else begin
                    l1_rdata <= l1_mem[idx];
                end
                l1_ack <= 1'b1;
                dropped = 1'b0;
                waited = 0;
                while (!dropped && waited < ACK_WAIT) begin
                    @(negedge clk_i);
                    dropped = (l1_req === 1'b0);
                    waited++;
                end
                if (!dropped) begin
                    $display("req still high %0d cycles after ack at %0t", ACK_WAIT, $time);
                    resp_errors++;
                end
                delay = $unsigned($random(seed)) % 4;
                repeat (delay) @(posedge clk_i);
                @(posedge clk_i);
                l1_ack <= 1'b0;
            end
        end
    end

    initial begin
        bit ok;
        int waited;
        bit timed_out;
        rstn_i    <= 1'b0;
        uop_valid <= 1'b0;
        uop_op    <= MEM_NONE;
        uop_a     <= '0;
        uop_b     <= '0;
        uop_imm   <= '0;
        uop_rd    <= '0;
        uop_tag   <= '0;
        timed_out = 1'b0;
        $readmemh("verif/mem_golden.txt", golden);

        repeat (4) @(posedge clk_i);
        @(negedge clk_i);
        if (stall !== 1'b0 || l1_req !== 1'b0 || wb_valid !== 1'b0) begin
            $display("outputs not low during reset: stall %b req %b wb_valid %b",
                     stall, l1_req, wb_valid);
            tb_errors++;
        end
        @(posedge clk_i);
        rstn_i <= 1'b1;
        @(posedge clk_i);

        for (int i = 0; i < N_OPS; i++) begin
            issue_uop(i, ok);
            if (!ok) begin
                $display("micro-op %0d was never taken, stall_o stayed high", i);
                tb_errors++;
                break;
            end
        end
        uop_valid <= 1'b0;

        waited = 0;
        while (wb_count < N_OPS && waited < DRAIN_WAIT) begin
            @(negedge clk_i);
            waited++;
        end
        if (wb_count < N_OPS) begin
            $display("timeout with only %0d of %0d write-backs seen", wb_count, N_OPS);
            timed_out = 1'b1;
        end
        repeat (8) @(negedge clk_i);    // room for a stray extra write-back

        $display("write-backs %0d of %0d, data errors %0d, protocol errors %0d, other errors %0d",
                 wb_count, N_OPS, data_errors, proto_errors, tb_errors + resp_errors);
        if (!timed_out && wb_count == N_OPS && data_errors == 0 && proto_errors == 0
            && tb_errors == 0 && resp_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== verif/mem_golden.txt ====
// op a b imm rd tag, then expected we and data; one micro-op per line, all hex
// op 0 none, 1 lb, 2 lh, 3 lw, 4 lbu, 5 lhu, 6 sb, 7 sh, 8 sw
0 12345678 00000000 00000000 01 0 1 12345678
0 DEADBEEF 11111111 00000010 00 1 0 DEADBEEF
3 00000000 00000000 00000004 02 2 1 81412111
1 00000008 00000000 00000003 03 3 1 FFFFFF82
4 00000008 00000000 00000003 04 4 1 00000082
1 00000010 00000000 FFFFFFFC 05 5 1 00000013
2 00000010 00000000 00000002 06 6 1 FFFF8444
5 00000014 00000000 00000000 07 7 1 00002515
2 00000014 00000000 00000003 08 8 1 FFFF8545
1 00000080 00000000 00000002 09 9 1 00000060
3 000000F0 00000000 0000000C 00 A 0 BF7F1F2F
8 00000020 CAFEF00D 00000000 0A B 0 00000000
3 00000020 00000000 00000000 0B C 1 CAFEF00D
6 00000024 000000A5 00000001 00 D 0 00000000
3 00000024 00000000 00000000 0C E 1 8949A519
7 00000030 00001234 00000002 01 F 0 00000000
3 00000030 00000000 00000000 0D 0 1 12342C1C
4 00000030 00000000 00000003 0E 1 1 00000012
2 00000030 00000000 00000000 0F 2 1 00002C1C
6 0000001C FFFFFF80 00000003 10 3 0 00000000
1 0000001C 00000000 00000003 11 4 1 FFFFFF80
0 0000FFFF 00000000 00000004 1F 5 1 0000FFFF
5 0000001C 00000000 00000002 12 6 1 00008047
0 76543210 00000000 00000000 13 7 1 76543210

// ==== tb.f ====
hdl/uop_pkg.sv
hdl/bus_pkg.sv
hdl/mem_op_decode.sv
hdl/data_bus_unit.sv
hdl/load_align.sv
hdl/mem_stage.sv
verif/mem_checker.sv
verif/tb_mem_stage.sv

// ==== Makefile ====
TOOL  = verilator
FLAGS = --binary --timing -j 0
TOP   = tb_mem_stage
FLIST = tb.f
BUILD = obj_dir

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | awk '{ print } /^Simulation finished: PASS$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(BUILD)
